/* hdl/io_device_access.sv */
`timescale 1ns/1ns

module io_device_access
	import io_fabric_pkg::*;
#(
	parameter int READ_LATENCY = 1
)
(
	input  logic     clk_sys,
	input  logic     reset,

	input  logic     valid,
	input  dev_id_e  dev_sel,
	input  logic     acc_write,
	input  io_reg_t  acc_reg,
	input  io_size_t acc_size,
	input  io_data_t acc_wdata,

	output logic     dev_read,
	output logic     dev_write,
	output dev_id_e  dev_sel_out,
	output io_reg_t  dev_reg,
	output io_byte_t dev_wdata,
	input  io_byte_t dev_rdata,

	output logic     done,
	output io_byte_t rdata,
	output io_byte_t syscfg
);

localparam int CNT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

logic             claimed;   // Decoded to a device on the external bus.
logic             disk_hit;
logic             key_write;
logic             busy;
logic [CNT_W-1:0] delay_cnt;
logic             claimed_rd;
logic             armed;     // Still waiting for the first disk access.

assign claimed   = (dev_sel != DEV_NONE) && (dev_sel != DEV_SYSCTL);
assign disk_hit  = (dev_sel == DEV_IDE0) || (dev_sel == DEV_IDE1) || (dev_sel == DEV_FLOPPY);
assign key_write = acc_write && (dev_sel == DEV_SYSCTL) && (acc_size == SYSCTL_SIZE) &&
	(acc_wdata[15:8] == SYSCTL_KEY);

always_ff @(posedge clk_sys) begin
	if (reset) begin
		dev_read    <= 1'b0;
		dev_write   <= 1'b0;
		dev_sel_out <= DEV_NONE;
		busy        <= 1'b0;
		delay_cnt   <= '0;
		done        <= 1'b0;
		claimed_rd  <= 1'b0;
	end else begin
		dev_read  <= valid && claimed && !acc_write; // Strobes last one cycle.
		dev_write <= valid && claimed && acc_write;
		done      <= 1'b0;
		if (valid) begin
			dev_sel_out <= dev_sel;
			claimed_rd  <= claimed && !acc_write;
			busy        <= 1'b1;
			delay_cnt   <= CNT_W'(READ_LATENCY - 1);
		end else if (busy) begin
			// Every access finishes at the same delay, claimed or not.
			if (delay_cnt == '0) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				delay_cnt <= delay_cnt - 1'b1;
			end
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (valid) begin
		dev_reg   <= acc_reg;
		dev_wdata <= acc_wdata[7:0];
	end
end

// The device byte is valid in the done cycle and is taken by the front stage.
assign rdata = claimed_rd ? dev_rdata : 8'hFF;

always_ff @(posedge clk_sys) begin
	if (reset) begin
		syscfg <= SYSCFG_RESET;
		armed  <= 1'b1;
	end else if (valid) begin
		if (armed && disk_hit) begin
			syscfg <= 8'h00; // The first disk access drops the power-on setting.
			armed  <= 1'b0;
		end else if (key_write) begin
			syscfg <= acc_wdata[7:0];
			armed  <= 1'b0;
		end
	end
end

a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
	!(dev_read && dev_write));

a_strobe_target: assert property (@(posedge clk_sys) disable iff (reset)
	(dev_read || dev_write) |-> (dev_sel_out != DEV_NONE) && (dev_sel_out != DEV_SYSCTL));

// Read data is handed back exactly at the device latency.
a_read_latency: assert property (@(posedge clk_sys) disable iff (reset)
	dev_read |-> ##READ_LATENCY done);

endmodule

/* hdl/io_fabric_pkg.sv */
package io_fabric_pkg;

	typedef logic [15:0] io_addr_t; // CPU port address.
	typedef logic [31:0] io_data_t; // CPU write and read data.
	typedef logic [7:0]  io_byte_t; // Device bus byte.
	typedef logic [2:0]  io_size_t; // Access size in bytes.
	typedef logic [3:0]  io_reg_t;  // Register offset inside a device.

	typedef enum logic [3:0] {
		DEV_NONE,
		DEV_IDE0,
		DEV_IDE1,
		DEV_FLOPPY,
		DEV_DMA,
		DEV_PIC,
		DEV_PIT,
		DEV_PS2,
		DEV_RTC,
		DEV_SOUND,
		DEV_UART1,
		DEV_UART2,
		DEV_MPU,
		DEV_VGA,
		DEV_JOY,
		DEV_SYSCTL
	} dev_id_e;

	// Each window is a base address and the number of low address bits it ignores.
	localparam io_addr_t IDE0_CMD_BASE    = 16'h01F0; localparam int IDE0_CMD_IGN    = 3;
	localparam io_addr_t IDE0_CTL_BASE    = 16'h03F6; localparam int IDE0_CTL_IGN    = 0;
	localparam io_addr_t IDE1_CMD_BASE    = 16'h0170; localparam int IDE1_CMD_IGN    = 3;
	localparam io_addr_t IDE1_CTL_BASE    = 16'h0376; localparam int IDE1_CTL_IGN    = 0;
	localparam io_addr_t FLOPPY_MAIN_BASE = 16'h03F0; localparam int FLOPPY_MAIN_IGN = 2;
	localparam io_addr_t FLOPPY_DATA_BASE = 16'h03F4; localparam int FLOPPY_DATA_IGN = 1;
	localparam io_addr_t FLOPPY_DIR_BASE  = 16'h03F7; localparam int FLOPPY_DIR_IGN  = 0;
	localparam io_addr_t DMA_MASTER_BASE  = 16'h00C0; localparam int DMA_MASTER_IGN  = 5;
	localparam io_addr_t DMA_PAGE_BASE    = 16'h0080; localparam int DMA_PAGE_IGN    = 4;
	localparam io_addr_t DMA_SLAVE_BASE   = 16'h0000; localparam int DMA_SLAVE_IGN   = 4;
	localparam io_addr_t PIC_MASTER_BASE  = 16'h0020; localparam int PIC_MASTER_IGN  = 1;
	localparam io_addr_t PIC_SLAVE_BASE   = 16'h00A0; localparam int PIC_SLAVE_IGN   = 1;
	localparam io_addr_t PIT_BASE         = 16'h0040; localparam int PIT_IGN         = 2;
	localparam io_addr_t PIT_SPK_BASE     = 16'h0061; localparam int PIT_SPK_IGN     = 0;
	localparam io_addr_t PS2_IO_BASE      = 16'h0060; localparam int PS2_IO_IGN      = 3;
	localparam io_addr_t PS2_CTL_BASE     = 16'h0090; localparam int PS2_CTL_IGN     = 4;
	localparam io_addr_t RTC_BASE         = 16'h0070; localparam int RTC_IGN         = 1;
	localparam io_addr_t FM_BASE          = 16'h0388; localparam int FM_IGN          = 2;
	localparam io_addr_t SB_BASE          = 16'h0220; localparam int SB_IGN          = 4;
	localparam io_addr_t UART1_BASE       = 16'h03F8; localparam int UART1_IGN       = 3;
	localparam io_addr_t UART2_BASE       = 16'h02F8; localparam int UART2_IGN       = 3;
	localparam io_addr_t MPU_BASE         = 16'h0330; localparam int MPU_IGN         = 1;
	localparam io_addr_t VGA_B_BASE       = 16'h03B0; localparam int VGA_B_IGN       = 4;
	localparam io_addr_t VGA_C_BASE       = 16'h03C0; localparam int VGA_C_IGN       = 4;
	localparam io_addr_t VGA_D_BASE       = 16'h03D0; localparam int VGA_D_IGN       = 4;
	localparam io_addr_t JOY_BASE         = 16'h0201; localparam int JOY_IGN         = 0;
	localparam io_addr_t SYSCTL_BASE      = 16'h8888; localparam int SYSCTL_IGN      = 0;

	// System control port.
	localparam io_byte_t SYSCFG_RESET = 8'hA2;
	localparam io_byte_t SYSCTL_KEY   = 8'hA1; // Expected in the upper write byte.
	localparam io_size_t SYSCTL_SIZE  = 3'd2;

endpackage

/* hdl/io_port_decode.sv */
`timescale 1ns/1ns

module io_port_decode
	import io_fabric_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,

	input  logic     start,
	input  logic     cap_write,
	input  io_addr_t cap_address,
	input  io_size_t cap_size,
	input  io_data_t cap_wdata,

	output logic     valid,
	output dev_id_e  dev_sel,
	output logic     acc_write,
	output io_reg_t  acc_reg,
	output io_size_t acc_size,
	output io_data_t acc_wdata
);

function automatic logic hit(io_addr_t addr, io_addr_t base, int ign);
	hit = (addr >> ign) == (base >> ign);
endfunction

dev_id_e sel_next;

// First match wins, so 03F6 goes to IDE0 and 0061 to the PIT.
always_comb begin
	sel_next = DEV_NONE;
	if (hit(cap_address, IDE0_CMD_BASE, IDE0_CMD_IGN) || hit(cap_address, IDE0_CTL_BASE, IDE0_CTL_IGN))
		sel_next = DEV_IDE0;
	else if (hit(cap_address, IDE1_CMD_BASE, IDE1_CMD_IGN) || hit(cap_address, IDE1_CTL_BASE, IDE1_CTL_IGN))
		sel_next = DEV_IDE1;
	else if (hit(cap_address, FLOPPY_MAIN_BASE, FLOPPY_MAIN_IGN) ||
		hit(cap_address, FLOPPY_DATA_BASE, FLOPPY_DATA_IGN) ||
		hit(cap_address, FLOPPY_DIR_BASE, FLOPPY_DIR_IGN))
		sel_next = DEV_FLOPPY;
	else if (hit(cap_address, DMA_MASTER_BASE, DMA_MASTER_IGN) ||
		hit(cap_address, DMA_PAGE_BASE, DMA_PAGE_IGN) ||
		hit(cap_address, DMA_SLAVE_BASE, DMA_SLAVE_IGN))
		sel_next = DEV_DMA;
	else if (hit(cap_address, PIC_MASTER_BASE, PIC_MASTER_IGN) || hit(cap_address, PIC_SLAVE_BASE, PIC_SLAVE_IGN))
		sel_next = DEV_PIC;
	else if (hit(cap_address, PIT_BASE, PIT_IGN) || hit(cap_address, PIT_SPK_BASE, PIT_SPK_IGN))
		sel_next = DEV_PIT;
	else if (hit(cap_address, PS2_IO_BASE, PS2_IO_IGN) || hit(cap_address, PS2_CTL_BASE, PS2_CTL_IGN))
		sel_next = DEV_PS2;
	else if (hit(cap_address, RTC_BASE, RTC_IGN))
		sel_next = DEV_RTC;
	else if (hit(cap_address, FM_BASE, FM_IGN) || hit(cap_address, SB_BASE, SB_IGN))
		sel_next = DEV_SOUND;
	else if (hit(cap_address, UART1_BASE, UART1_IGN))
		sel_next = DEV_UART1;
	else if (hit(cap_address, UART2_BASE, UART2_IGN))
		sel_next = DEV_UART2;
	else if (hit(cap_address, MPU_BASE, MPU_IGN))
		sel_next = DEV_MPU;
	else if (hit(cap_address, VGA_B_BASE, VGA_B_IGN) || hit(cap_address, VGA_C_BASE, VGA_C_IGN) ||
		hit(cap_address, VGA_D_BASE, VGA_D_IGN))
		sel_next = DEV_VGA;
	else if (hit(cap_address, JOY_BASE, JOY_IGN))
		sel_next = DEV_JOY;
	else if (hit(cap_address, SYSCTL_BASE, SYSCTL_IGN))
		sel_next = DEV_SYSCTL;
end

always_ff @(posedge clk_sys) begin
	if (reset) begin
		valid   <= 1'b0;
		dev_sel <= DEV_NONE;
	end else begin
		valid <= start;
		if (start)
			dev_sel <= sel_next;
	end
end

always_ff @(posedge clk_sys) begin
	if (start) begin
		acc_write <= cap_write;
		acc_reg   <= cap_address[3:0];
		acc_size  <= cap_size;
		acc_wdata <= cap_wdata;
	end
end

// One access in flight means the stage pulse never runs back to back.
a_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset) valid |=> !valid);

endmodule

/* hdl/io_port_fabric.sv */
`timescale 1ns/1ns

module io_port_fabric
	import io_fabric_pkg::*;
#(
	parameter int READ_LATENCY = 1
)
(
	input  logic     clk_sys,
	input  logic     reset,

	input  logic     req,
	input  logic     io_write,
	input  io_addr_t io_address,
	input  io_size_t io_size,
	input  io_data_t io_wdata,
	output logic     ack,
	output io_data_t io_rdata,

	output dev_id_e  dev_sel,
	output logic     dev_read,
	output logic     dev_write,
	output io_reg_t  dev_reg,
	output io_byte_t dev_wdata,
	input  io_byte_t dev_rdata,

	output io_byte_t syscfg
);

logic     start;
logic     cap_write;
io_addr_t cap_address;
io_size_t cap_size;
io_data_t cap_wdata;

logic     valid;
dev_id_e  dec_sel;
logic     acc_write;
io_reg_t  acc_reg;
io_size_t acc_size;
io_data_t acc_wdata;

logic     done;
io_byte_t rdata;

io_request_port request_port (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.req         (req),
	.io_write    (io_write),
	.io_address  (io_address),
	.io_size     (io_size),
	.io_wdata    (io_wdata),
	.ack         (ack),
	.io_rdata    (io_rdata),
	.start       (start),
	.cap_write   (cap_write),
	.cap_address (cap_address),
	.cap_size    (cap_size),
	.cap_wdata   (cap_wdata),
	.done        (done),
	.rdata       (rdata)
);

io_port_decode port_decode (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.start       (start),
	.cap_write   (cap_write),
	.cap_address (cap_address),
	.cap_size    (cap_size),
	.cap_wdata   (cap_wdata),
	.valid       (valid),
	.dev_sel     (dec_sel),
	.acc_write   (acc_write),
	.acc_reg     (acc_reg),
	.acc_size    (acc_size),
	.acc_wdata   (acc_wdata)
);

io_device_access #(
	.READ_LATENCY (READ_LATENCY)
) device_access (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.valid       (valid),
	.dev_sel     (dec_sel),
	.acc_write   (acc_write),
	.acc_reg     (acc_reg),
	.acc_size    (acc_size),
	.acc_wdata   (acc_wdata),
	.dev_read    (dev_read),
	.dev_write   (dev_write),
	.dev_sel_out (dev_sel),
	.dev_reg     (dev_reg),
	.dev_wdata   (dev_wdata),
	.dev_rdata   (dev_rdata),
	.done        (done),
	.rdata       (rdata),
	.syscfg      (syscfg)
);

endmodule

/* hdl/io_request_port.sv */
`timescale 1ns/1ns

module io_request_port
	import io_fabric_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,

	input  logic     req,
	input  logic     io_write,
	input  io_addr_t io_address,
	input  io_size_t io_size,
	input  io_data_t io_wdata,
	output logic     ack,
	output io_data_t io_rdata,

	output logic     start,
	output logic     cap_write,
	output io_addr_t cap_address,
	output io_size_t cap_size,
	output io_data_t cap_wdata,
	input  logic     done,
	input  io_byte_t rdata
);

typedef enum logic [1:0] {
	IDLE,
	BUSY,
	ACKED
} state_e;

state_e state;

logic take; // An access is accepted on this edge.

assign take = (state == IDLE) && req;

always_ff @(posedge clk_sys) begin
	if (reset) begin
		state <= IDLE;
		start <= 1'b0;
		ack   <= 1'b0;
	end else begin
		start <= take;
		case (state)
			IDLE: begin
				if (req)
					state <= BUSY;
			end
			BUSY: begin
				if (done) begin
					state <= ACKED;
					ack   <= 1'b1;
				end
			end
			ACKED: begin
				// The requester has seen ack and let go of req.
				if (!req) begin
					state <= IDLE;
					ack   <= 1'b0;
				end
			end
			default: state <= IDLE;
		endcase
	end
end

// The requester holds its fields steady, so one capture per access is enough.
always_ff @(posedge clk_sys) begin
	if (take) begin
		cap_write   <= io_write;
		cap_address <= io_address;
		cap_size    <= io_size;
		cap_wdata   <= io_wdata;
	end
	if (state == BUSY && done)
		io_rdata <= cap_write ? '0 : io_data_t'(rdata); // Writes return zeros.
end

// The back end only answers an access that this stage has handed out.
a_done_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
	done |-> state == BUSY);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_io_port_fabric \
	--Mdir obj_dir -o tb_io_port_fabric \
	-f tb.f

./obj_dir/tb_io_port_fabric | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

echo "Simulation finished without failures"

/* sim/tb_io_port_fabric.sv */
`timescale 1ns/1ns

module tb_io_port_fabric
	import io_fabric_pkg::*;
();

localparam int READ_LATENCY   = 2;
localparam int RESET_CYCLES   = 8;
localparam int NUM_ACCESSES   = 27;
localparam int TIMEOUT_CYCLES = NUM_ACCESSES * (3 + READ_LATENCY + 4) + RESET_CYCLES;

logic     clk_sys;
logic     reset;
logic     req;
logic     io_write;
io_addr_t io_address;
io_size_t io_size;
io_data_t io_wdata;
logic     ack;
io_data_t io_rdata;
dev_id_e  dev_sel;
logic     dev_read;
logic     dev_write;
io_reg_t  dev_reg;
io_byte_t dev_wdata;
io_byte_t dev_rdata;
io_byte_t syscfg;

int          value_errors = 0;
int          other_errors = 0;
int          cycle_count  = 0;
int          rd_count     = 0; // Strobes seen on the device bus.
int          wr_count     = 0;
dev_id_e     seen_sel;
io_reg_t     seen_reg;
io_byte_t    resp_byte    = 8'h00; // Byte the device returns on its next read.
logic [31:0] lcg_state    = 32'h393e4155;

io_port_fabric #(
	.READ_LATENCY (READ_LATENCY)
) DUT (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.req        (req),
	.io_write   (io_write),
	.io_address (io_address),
	.io_size    (io_size),
	.io_wdata   (io_wdata),
	.ack        (ack),
	.io_rdata   (io_rdata),
	.dev_sel    (dev_sel),
	.dev_read   (dev_read),
	.dev_write  (dev_write),
	.dev_reg    (dev_reg),
	.dev_wdata  (dev_wdata),
	.dev_rdata  (dev_rdata),
	.syscfg     (syscfg)
);

initial begin
	clk_sys = 1'b0;
	forever #10 clk_sys = ~clk_sys;
end

always @(posedge clk_sys) begin
	cycle_count++;
	if (cycle_count >= TIMEOUT_CYCLES) begin
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end
end

// Strobes are sampled mid-cycle, where they are stable.
always @(negedge clk_sys) begin
	if (dev_read) begin
		rd_count++;
		seen_sel = dev_sel;
		seen_reg = dev_reg;
	end
	if (dev_write) begin
		wr_count++;
		seen_sel = dev_sel;
		seen_reg = dev_reg;
	end
end

// The device model returns its byte READ_LATENCY cycles after the strobe for one cycle.
always @(negedge clk_sys) begin
	if (dev_read) begin
		repeat (READ_LATENCY) @(posedge clk_sys);
		#2 dev_rdata = resp_byte;
		@(posedge clk_sys);
		#2 dev_rdata = 8'h00;
	end
end

function automatic io_byte_t lcg_byte();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state[23:16];
endfunction

task automatic check_byte(input string name, input io_byte_t got, input io_byte_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_dev(input string name, input dev_id_e got, input dev_id_e exp);
	if (got !== exp) begin
		value_errors++;
		$display("error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		value_errors++;
		$display("error: %s got %h expected %h", name, got, exp);
	end
endtask

// One four-phase transfer; rise counts edges from req sampled high to ack seen high.
task automatic io_access(input logic wr, input io_addr_t addr, input io_size_t size,
	input io_data_t wdata, output io_data_t rdata, output int rise, output int fall);
	io_write   = wr;
	io_address = addr;
	io_size    = size;
	io_wdata   = wdata;
	req        = 1'b1;
	@(posedge clk_sys);
	#2;
	rise = 0;
	while (!ack) begin
		@(posedge clk_sys);
		#2;
		rise++;
	end
	rdata = io_rdata;
	req   = 1'b0;
	fall  = 0;
	while (ack) begin
		@(posedge clk_sys);
		#2;
		fall++;
	end
endtask

task automatic read_claimed(input io_addr_t addr, input dev_id_e exp_dev);
	io_data_t rdata;
	int       rise;
	int       fall;
	int       rd_before;
	io_byte_t exp_byte;
	exp_byte  = lcg_byte();
	resp_byte = exp_byte;
	rd_before = rd_count;
	io_access(1'b0, addr, 3'd1, '0, rdata, rise, fall);
	check_count("dev_read pulses", rd_count - rd_before, 1);
	check_dev("dev_sel", seen_sel, exp_dev);
	check_byte("dev_reg", io_byte_t'(seen_reg), io_byte_t'(addr[3:0]));
	check_byte("io_rdata", rdata[7:0], exp_byte);
	check_byte("io_rdata upper", io_byte_t'(rdata[31:8] != 0), 8'h00);
endtask

task automatic read_unclaimed(input io_addr_t addr);
	io_data_t rdata;
	int       rise;
	int       fall;
	int       strobes_before;
	strobes_before = rd_count + wr_count;
	io_access(1'b0, addr, 3'd1, '0, rdata, rise, fall);
	check_count("device strobes", rd_count + wr_count - strobes_before, 0);
	check_byte("io_rdata", rdata[7:0], 8'hFF);
endtask

task automatic write_port(input io_addr_t addr, input io_size_t size, input io_data_t wdata,
	input int exp_strobes, input io_byte_t exp_syscfg);
	io_data_t rdata;
	int       rise;
	int       fall;
	int       wr_before;
	wr_before = wr_count;
	io_access(1'b1, addr, size, wdata, rdata, rise, fall);
	check_count("dev_write pulses", wr_count - wr_before, exp_strobes);
	check_byte("syscfg", syscfg, exp_syscfg);
endtask

task automatic test_reset_state();
	check_byte("syscfg", syscfg, 8'hA2);
	if (ack !== 1'b0) begin
		other_errors++;
		$display("ack is not low after reset");
	end
endtask

task automatic test_control_clear();
	write_port(16'h03F2, 3'd1, 32'h0000_0011, 1, 8'h00); // First floppy access.
	check_byte("dev_wdata", dev_wdata, 8'h11);
	write_port(16'h8888, 3'd2, 32'h0000_A15A, 0, 8'h5A);
	read_claimed(16'h01F0, DEV_IDE0);
	check_byte("syscfg", syscfg, 8'h5A);
endtask

task automatic test_control_reject();
	write_port(16'h8888, 3'd2, 32'h0000_A1C3, 0, 8'hC3); // Differs from both rejected bytes.
	write_port(16'h8888, 3'd2, 32'h0000_B15A, 0, 8'hC3);
	write_port(16'h8888, 3'd1, 32'h0000_A133, 0, 8'hC3);
endtask

task automatic test_decode();
	read_claimed(16'h01F7, DEV_IDE0);
	read_claimed(16'h03F6, DEV_IDE0);
	read_claimed(16'h0171, DEV_IDE1);
	read_claimed(16'h03F5, DEV_FLOPPY);
	read_claimed(16'h00D3, DEV_DMA);
	read_claimed(16'h0021, DEV_PIC);
	read_claimed(16'h0061, DEV_PIT);
	read_claimed(16'h0064, DEV_PS2);
	read_claimed(16'h0071, DEV_RTC);
	read_claimed(16'h022A, DEV_SOUND);
	read_claimed(16'h038B, DEV_SOUND);
	read_claimed(16'h03FA, DEV_UART1);
	read_claimed(16'h02F9, DEV_UART2);
	read_claimed(16'h0331, DEV_MPU);
	read_claimed(16'h03C5, DEV_VGA);
	read_claimed(16'h0201, DEV_JOY);
endtask

task automatic test_unclaimed();
	read_unclaimed(16'h0300);
	read_unclaimed(16'h1234);
	read_unclaimed(16'h8888);
endtask

task automatic test_handshake();
	io_data_t rdata;
	int       rise;
	int       fall;
	io_byte_t exp_byte;
	exp_byte  = lcg_byte();
	resp_byte = exp_byte;
	io_access(1'b0, 16'h03F9, 3'd1, '0, rdata, rise, fall);
	check_count("read ack rise cycles", rise, 3 + READ_LATENCY);
	check_count("read ack fall cycles", fall, 1);
	check_byte("io_rdata", rdata[7:0], exp_byte);
	io_access(1'b1, 16'h0070, 3'd1, 32'h0000_0005, rdata, rise, fall);
	check_count("write ack rise cycles", rise, 3 + READ_LATENCY);
	check_count("write ack fall cycles", fall, 1);
endtask

initial begin
	reset      = 1'b1;
	req        = 1'b0;
	io_write   = 1'b0;
	io_address = '0;
	io_size    = 3'd1;
	io_wdata   = '0;
	dev_rdata  = 8'h00;
	repeat (RESET_CYCLES) @(posedge clk_sys);
	#2 reset = 1'b0;

	test_reset_state();
	test_control_clear(); // Needs to be the first access after reset.
	test_control_reject();
	test_decode();
	test_unclaimed();
	test_handshake();

	$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
	if (value_errors == 0 && other_errors == 0)
		$display("TB PASSED");
	else
		$display("TB FAILED");
	$finish;
end

endmodule

/* tb.f */
hdl/io_fabric_pkg.sv
hdl/io_request_port.sv
hdl/io_port_decode.sv
hdl/io_device_access.sv
hdl/io_port_fabric.sv
sim/tb_io_port_fabric.sv
